//--- logic/buffer_geom_pkg.sv
`default_nettype none

package buffer_geom_pkg;

  // Data line.
  localparam int line_w = 32;

  // Chunk geometry.
  localparam int lines_per_chunk = 4;
  localparam int chunk_count     = 16;

  // Address fields.
  localparam int offs_w      = 2;                 // Line offset inside a chunk.
  localparam int chunk_w     = 4;                 // Chunk number.
  localparam int line_addr_w = chunk_w + offs_w;  // Chunk number above offset.

  // Link entry holds the next chunk number above the last flag.
  localparam int link_w = chunk_w + 1;

endpackage

`default_nettype wire

//--- logic/buffer_ctrl_pkg.sv
`default_nettype none

package buffer_ctrl_pkg;

  // Read side states.
  typedef enum logic [2:0] {
    idle       = 3'd0,
    prefetch   = 3'd1,  // Line 0 of the head chunk is fetched.
    rd         = 3'd2,
    wait_rel   = 3'd3,  // Whole chain read out and freed.
    rel_delay1 = 3'd4,
    rel_delay2 = 3'd5,
    rel_wr2fl  = 3'd6   // Chunk goes back to the free list.
  } rd_state_t;

  // Free list almost-empty level.
  localparam int fl_aempty_lvl = 2;

endpackage

`default_nettype wire

//--- logic/simple_dp_ram.sv
`timescale 1ns/1ps
`default_nettype none

module simple_dp_ram #(
  parameter int data_w = 32,
  parameter int addr_w = 6
) (
  input  logic              clk,
  input  logic              wr_en,
  input  logic [addr_w-1:0] wr_addr,
  input  logic [data_w-1:0] wr_data,
  input  logic              rd_en,
  input  logic [addr_w-1:0] rd_addr,
  output logic [data_w-1:0] rd_data
);

  logic [data_w-1:0] mem [0:(1 << addr_w)-1];

  always_ff @(posedge clk)
  begin
    if (wr_en)
      mem[wr_addr] <= wr_data;
  end

  // Output register holds its word between reads.
  always_ff @(posedge clk)
  begin
    if (rd_en)
      rd_data <= mem[rd_addr];
  end

endmodule

`default_nettype wire

//--- logic/free_chunk_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module free_chunk_fifo (
  input  logic                                clk,
  input  logic                                reset_n,
  input  logic                                push,
  input  logic [buffer_geom_pkg::chunk_w-1:0] push_data,
  input  logic                                pop,
  output logic [buffer_geom_pkg::chunk_w-1:0] head,
  output logic                                empty,
  output logic                                aempty,
  output logic                                filling
);

  logic [buffer_geom_pkg::chunk_w-1:0] ring [0:buffer_geom_pkg::chunk_count-1];
  logic [buffer_geom_pkg::chunk_w-1:0] wr_ptr;
  logic [buffer_geom_pkg::chunk_w-1:0] rd_ptr;
  logic [buffer_geom_pkg::chunk_w:0]   level;
  logic [2:0]                          start_sr;
  logic [buffer_geom_pkg::chunk_w-1:0] fill_cnt;
  logic                                full;
  logic                                wr_en;
  logic [buffer_geom_pkg::chunk_w-1:0] wr_data;

  assign wr_en   = filling | push;
  assign wr_data = filling ? fill_cnt : push_data;  // Fill wins over returned chunks.
  assign full    = level == (buffer_geom_pkg::chunk_w + 1)'(buffer_geom_pkg::chunk_count);
  assign empty   = level == '0;
  assign aempty  = level <= (buffer_geom_pkg::chunk_w + 1)'(buffer_ctrl_pkg::fl_aempty_lvl);
  assign head    = ring[rd_ptr];  // Show-ahead.

  // Self-fill with every chunk number, three cycles out of reset.
  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      start_sr <= '0;
      filling  <= 1'b0;
      fill_cnt <= '0;
    end
    else
    begin
      start_sr <= {start_sr[1:0], 1'b1};
      if (start_sr[1] && !start_sr[2])
        filling <= 1'b1;
      else if (fill_cnt == buffer_geom_pkg::chunk_w'(buffer_geom_pkg::chunk_count - 1))
        filling <= 1'b0;
      fill_cnt <= filling ? fill_cnt + 1'b1 : '0;
    end
  end

  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      level  <= '0;
    end
    else
    begin
      if (wr_en)
        wr_ptr <= wr_ptr + 1'b1;  // Wraps with the ring.
      if (pop)
        rd_ptr <= rd_ptr + 1'b1;
      case ({wr_en, pop})
        2'b10:   level <= level + 1'b1;
        2'b01:   level <= level - 1'b1;
        default: level <= level;
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (wr_en)
      ring[wr_ptr] <= wr_data;
  end

  a_no_overflow: assert property (@(posedge clk) disable iff (!reset_n) wr_en |-> !full)
    else $error("free list pushed while full");

  a_no_underflow: assert property (@(posedge clk) disable iff (!reset_n) pop |-> !empty)
    else $error("free list popped while empty");

endmodule

`default_nettype wire

//--- logic/chunk_write_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module chunk_write_ctrl (
  input  logic                                    clk,
  input  logic                                    reset_n,
  input  logic                                    wren,
  input  logic                                    eop,
  input  logic [buffer_geom_pkg::chunk_w-1:0]     fl_q,
  input  logic                                    fl_empty,
  output logic                                    fl_rden,
  output logic [buffer_geom_pkg::line_addr_w-1:0] ram_wr_addr,
  output logic                                    ll_wren,
  output logic [buffer_geom_pkg::chunk_w-1:0]     ll_wr_addr,
  output logic [buffer_geom_pkg::link_w-1:0]      ll_data
);

  logic                                    sop;
  logic [buffer_geom_pkg::line_addr_w-1:0] wr_addr_lat;  // Last write address.
  logic                                    eop_pend;
  logic                                    new_chunk;
  logic                                    first_line;
  logic                                    eop_late;
  logic                                    last_flag;

  // Fresh chunk at start of packet or after the last offset was written.
  assign new_chunk = sop ||
                     (wren && wr_addr_lat[buffer_geom_pkg::offs_w-1:0] ==
                      buffer_geom_pkg::offs_w'(buffer_geom_pkg::lines_per_chunk - 1));

  assign ram_wr_addr = new_chunk ? {fl_q, {buffer_geom_pkg::offs_w{1'b0}}} :
                       wren      ? wr_addr_lat + 1'b1 :
                                   wr_addr_lat;

  assign first_line = wren && new_chunk;  // Line lands at offset 0.
  assign eop_late   = wren && eop && !new_chunk;

  // Link of the previous chunk goes out as the next one is taken.
  assign ll_wren    = (first_line && !sop) || eop_late || eop_pend;
  assign last_flag  = eop_late || eop_pend;
  assign ll_wr_addr = wr_addr_lat[buffer_geom_pkg::line_addr_w-1:buffer_geom_pkg::offs_w];
  assign ll_data    = {fl_q, last_flag};

  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      sop         <= 1'b1;
      wr_addr_lat <= '0;
      eop_pend    <= 1'b0;
      fl_rden     <= 1'b0;
    end
    else
    begin
      if (wren)
        sop <= eop;
      wr_addr_lat <= ram_wr_addr;
      eop_pend    <= first_line && eop;  // Last flag of the new chunk comes a cycle later.
      fl_rden     <= first_line;
    end
  end

  a_wr_has_chunk: assert property (@(posedge clk) disable iff (!reset_n) wren |-> !fl_empty)
    else $error("write while free list is empty");

endmodule

`default_nettype wire

//--- logic/chunk_read_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module chunk_read_ctrl (
  input  logic                                    clk,
  input  logic                                    reset_n,
  input  logic                                    filling,
  input  logic [buffer_geom_pkg::chunk_w-1:0]     chunk_num,
  input  logic                                    load_req,
  input  logic                                    rel_req,
  input  logic                                    rden,
  input  logic [buffer_geom_pkg::link_w-1:0]      ll_q,
  output logic [buffer_geom_pkg::chunk_w-1:0]     ll_rd_addr,
  output logic [buffer_geom_pkg::line_addr_w-1:0] ram_rd_addr,
  output logic                                    ram_rd_en,
  output logic                                    fl_wren,
  output logic [buffer_geom_pkg::chunk_w-1:0]     fl_data,
  output logic                                    load_rel_ack
);

  buffer_ctrl_pkg::rd_state_t              state;
  buffer_ctrl_pkg::rd_state_t              next_state;
  logic                                    load_req_r;
  logic                                    load_rise;
  logic                                    idle_start;
  logic [buffer_geom_pkg::chunk_w-1:0]     link_addr;  // Chunk not yet returned.
  logic [buffer_geom_pkg::line_addr_w-1:0] usr_addr;   // Line now on dout.
  logic [buffer_geom_pkg::chunk_w-1:0]     nxt_ptr;
  logic                                    rel_mask;
  logic                                    steer;
  logic                                    rd_step;
  logic                                    rd_free;
  logic                                    rd_done;
  logic                                    rel_start;
  logic                                    rel_push;

  assign load_rise  = load_req && !load_req_r;
  assign idle_start = state == buffer_ctrl_pkg::idle && !filling && (rel_req || load_rise);
  assign nxt_ptr    = ll_q[buffer_geom_pkg::link_w-1:1];

  assign rd_step = state == buffer_ctrl_pkg::rd && rden;
  assign rd_free = rd_step && usr_addr[buffer_geom_pkg::offs_w-1:0] ==
                   buffer_geom_pkg::offs_w'(buffer_geom_pkg::lines_per_chunk - 1);
  assign rd_done = rd_free && ll_q[0];  // Last line of the last chunk consumed.

  assign rel_start = (state == buffer_ctrl_pkg::idle && !filling && rel_req) ||
                     (state == buffer_ctrl_pkg::rd && rel_req && !rd_done);
  assign rel_push  = state == buffer_ctrl_pkg::rel_wr2fl;

  // First chunk of a release is read at link_addr, later ones follow the link.
  assign steer      = state == buffer_ctrl_pkg::rel_delay1 && !rel_mask;
  assign ll_rd_addr = steer ? nxt_ptr : link_addr;
  assign ram_rd_en  = state == buffer_ctrl_pkg::prefetch || rd_step;

  always_comb
  begin
    next_state = state;
    case (state)
      buffer_ctrl_pkg::idle:
      begin
        if (!filling && rel_req)
          next_state = buffer_ctrl_pkg::rel_delay1;
        else if (!filling && load_rise)
          next_state = buffer_ctrl_pkg::prefetch;
      end
      buffer_ctrl_pkg::prefetch:
        next_state = buffer_ctrl_pkg::rd;
      buffer_ctrl_pkg::rd:
      begin
        if (rd_done)
          next_state = buffer_ctrl_pkg::wait_rel;
        else if (rel_req)
          next_state = buffer_ctrl_pkg::rel_delay1;
      end
      buffer_ctrl_pkg::wait_rel:
      begin
        if (rel_req)
          next_state = buffer_ctrl_pkg::idle;
      end
      buffer_ctrl_pkg::rel_delay1:
        next_state = buffer_ctrl_pkg::rel_delay2;
      buffer_ctrl_pkg::rel_delay2:
        next_state = buffer_ctrl_pkg::rel_wr2fl;
      buffer_ctrl_pkg::rel_wr2fl:
        next_state = ll_q[0] ? buffer_ctrl_pkg::idle : buffer_ctrl_pkg::rel_delay1;
      default:
        next_state = buffer_ctrl_pkg::idle;
    endcase
  end

  always_comb
  begin
    case (state)
      buffer_ctrl_pkg::prefetch:  load_rel_ack = 1'b1;
      buffer_ctrl_pkg::wait_rel:  load_rel_ack = rel_req;
      buffer_ctrl_pkg::rel_wr2fl: load_rel_ack = ll_q[0];  // End of chain.
      default:                    load_rel_ack = 1'b0;
    endcase
  end

  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      state       <= buffer_ctrl_pkg::idle;
      load_req_r  <= 1'b0;
      rel_mask    <= 1'b0;
      link_addr   <= '0;
      ram_rd_addr <= '0;
      usr_addr    <= '0;
      fl_wren     <= 1'b0;
      fl_data     <= '0;
    end
    else
    begin
      state      <= next_state;
      load_req_r <= load_req;

      if (rel_start)
        rel_mask <= 1'b1;
      else if (rel_push)
        rel_mask <= 1'b0;

      if (idle_start)
        link_addr <= chunk_num;
      else if (rd_free || steer)
        link_addr <= nxt_ptr;

      if (state == buffer_ctrl_pkg::idle && load_rise)
        ram_rd_addr <= {chunk_num, {buffer_geom_pkg::offs_w{1'b0}}};
      else if (ram_rd_en && ram_rd_addr[buffer_geom_pkg::offs_w-1:0] ==
               buffer_geom_pkg::offs_w'(buffer_geom_pkg::lines_per_chunk - 1))
        ram_rd_addr <= {nxt_ptr, {buffer_geom_pkg::offs_w{1'b0}}};  // Follow the link.
      else if (ram_rd_en)
        ram_rd_addr <= ram_rd_addr + 1'b1;

      if (ram_rd_en)
        usr_addr <= ram_rd_addr;

      fl_wren <= rd_free || rel_push;
      fl_data <= rel_push ? link_addr :
                 usr_addr[buffer_geom_pkg::line_addr_w-1:buffer_geom_pkg::offs_w];
    end
  end

  a_ack_single: assert property (@(posedge clk) disable iff (!reset_n)
    (load_rel_ack && state != buffer_ctrl_pkg::wait_rel) |=>
    !(load_rel_ack && state != buffer_ctrl_pkg::wait_rel))
    else $error("load_rel_ack held for two cycles");

endmodule

`default_nettype wire

//--- logic/chunk_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module chunk_buffer (
  input  logic                                clk,
  input  logic                                reset_n,
  input  logic                                wren,
  input  logic [buffer_geom_pkg::line_w-1:0]  din,
  input  logic                                eop,
  input  logic [buffer_geom_pkg::chunk_w-1:0] chunk_num,
  input  logic                                load_req,
  input  logic                                rel_req,
  input  logic                                rden,
  output logic [buffer_geom_pkg::chunk_w-1:0] fl_q,
  output logic                                fl_empty,
  output logic                                fl_aempty,
  output logic                                load_rel_ack,
  output logic [buffer_geom_pkg::line_w-1:0]  dout
);

  logic [buffer_geom_pkg::line_addr_w-1:0] ram_wr_addr;
  logic [buffer_geom_pkg::line_addr_w-1:0] ram_rd_addr;
  logic                                    ram_rd_en;
  logic                                    fl_rden;
  logic                                    fl_wren;
  logic [buffer_geom_pkg::chunk_w-1:0]     fl_data;
  logic                                    filling;
  logic                                    ll_wren;
  logic [buffer_geom_pkg::chunk_w-1:0]     ll_wr_addr;
  logic [buffer_geom_pkg::link_w-1:0]      ll_data;
  logic [buffer_geom_pkg::chunk_w-1:0]     ll_rd_addr;
  logic [buffer_geom_pkg::link_w-1:0]      ll_q;

  simple_dp_ram #(
    .data_w (buffer_geom_pkg::line_w),
    .addr_w (buffer_geom_pkg::line_addr_w)
  ) u_data_ram (
    .clk     (clk),
    .wr_en   (wren),
    .wr_addr (ram_wr_addr),
    .wr_data (din),
    .rd_en   (ram_rd_en),
    .rd_addr (ram_rd_addr),
    .rd_data (dout)
  );

  simple_dp_ram #(
    .data_w (buffer_geom_pkg::link_w),
    .addr_w (buffer_geom_pkg::chunk_w)
  ) u_link_ram (
    .clk     (clk),
    .wr_en   (ll_wren),
    .wr_addr (ll_wr_addr),
    .wr_data (ll_data),
    .rd_en   (1'b1),      // Link word follows the address every cycle.
    .rd_addr (ll_rd_addr),
    .rd_data (ll_q)
  );

  free_chunk_fifo u_free_list (
    .clk       (clk),
    .reset_n   (reset_n),
    .push      (fl_wren),
    .push_data (fl_data),
    .pop       (fl_rden),
    .head      (fl_q),
    .empty     (fl_empty),
    .aempty    (fl_aempty),
    .filling   (filling)
  );

  chunk_write_ctrl u_write_ctrl (
    .clk         (clk),
    .reset_n     (reset_n),
    .wren        (wren),
    .eop         (eop),
    .fl_q        (fl_q),
    .fl_empty    (fl_empty),
    .fl_rden     (fl_rden),
    .ram_wr_addr (ram_wr_addr),
    .ll_wren     (ll_wren),
    .ll_wr_addr  (ll_wr_addr),
    .ll_data     (ll_data)
  );

  chunk_read_ctrl u_read_ctrl (
    .clk          (clk),
    .reset_n      (reset_n),
    .filling      (filling),
    .chunk_num    (chunk_num),
    .load_req     (load_req),
    .rel_req      (rel_req),
    .rden         (rden),
    .ll_q         (ll_q),
    .ll_rd_addr   (ll_rd_addr),
    .ram_rd_addr  (ram_rd_addr),
    .ram_rd_en    (ram_rd_en),
    .fl_wren      (fl_wren),
    .fl_data      (fl_data),
    .load_rel_ack (load_rel_ack)
  );

endmodule

`default_nettype wire

//--- bench/chunk_buffer_tb.sv
`timescale 1ns/1ps
`default_nettype none

module chunk_buffer_tb;

  // Roughly 60 cycles per packet over about 100 packets with a threefold margin.
  localparam int max_cycles = 20000;

  logic                                clk;
  logic                                reset_n;
  logic                                wren;
  logic [buffer_geom_pkg::line_w-1:0]  din;
  logic                                eop;
  logic [buffer_geom_pkg::chunk_w-1:0] chunk_num;
  logic                                load_req;
  logic                                rel_req;
  logic                                rden;
  logic [buffer_geom_pkg::chunk_w-1:0] fl_q;
  logic                                fl_empty;
  logic                                fl_aempty;
  logic                                load_rel_ack;
  logic [buffer_geom_pkg::line_w-1:0]  dout;

  logic                                ack_s;  // load_rel_ack at the last rising edge.
  int                                  cycle_cnt;
  logic [buffer_geom_pkg::chunk_w-1:0] free_q [$];
  logic [buffer_geom_pkg::chunk_w-1:0] heads [$];
  logic [buffer_geom_pkg::line_w-1:0]  mem_m [0:(1 << buffer_geom_pkg::line_addr_w)-1];
  bit                                  mem_v [0:(1 << buffer_geom_pkg::line_addr_w)-1];
  logic [buffer_geom_pkg::chunk_w-1:0] link_nxt [0:buffer_geom_pkg::chunk_count-1];
  bit                                  link_last [0:buffer_geom_pkg::chunk_count-1];

  chunk_buffer chunk_buffer_i (
    .clk (clk), .reset_n (reset_n), .wren (wren), .din (din), .eop (eop),
    .chunk_num (chunk_num), .load_req (load_req), .rel_req (rel_req), .rden (rden),
    .fl_q (fl_q), .fl_empty (fl_empty), .fl_aempty (fl_aempty),
    .load_rel_ack (load_rel_ack), .dout (dout)
  );

  initial
  begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  always @(posedge clk)
  begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt >= max_cycles)
      stop_run($sformatf("timeout, the run did not end within %0d cycles", max_cycles));
  end

  task automatic stop_run(input string line);
    $display("%s", line);
    $display("Something failed");
    $fatal(1);
  endtask

  task automatic check_line(input logic [buffer_geom_pkg::line_w-1:0] got,
                            input logic [buffer_geom_pkg::line_w-1:0] exp, input string what);
    if (got !== exp)
      stop_run($sformatf("mismatch at %0t: %s, got %h, expected %h", $time, what, got, exp));
  endtask

  task automatic check_chunk(input logic [buffer_geom_pkg::chunk_w-1:0] got,
                             input logic [buffer_geom_pkg::chunk_w-1:0] exp, input string what);
    if (got !== exp)
      stop_run($sformatf("mismatch at %0t: %s, got %0d, expected %0d", $time, what, got, exp));
  endtask

  task automatic check_flag(input logic got, input logic exp, input string what);
    if (got !== exp)
      stop_run($sformatf("mismatch at %0t: %s, got %b, expected %b", $time, what, got, exp));
  endtask

  // Returns at the falling edge where inputs change.
  task automatic cycle;
    @(posedge clk);
    ack_s = load_rel_ack;
    @(negedge clk);
  endtask

  task automatic settle;
    repeat (3) cycle();
    check_flag(fl_empty, free_q.size() == 0, "fl_empty against model level");
    check_flag(fl_aempty, free_q.size() <= buffer_ctrl_pkg::fl_aempty_lvl,
               "fl_aempty against model level");
    if (free_q.size() > 0)
      check_chunk(fl_q, free_q[0], "free list head");
  endtask

  task automatic write_packet(input int len, output logic [buffer_geom_pkg::chunk_w-1:0] head);
    logic [buffer_geom_pkg::chunk_w-1:0]     cur;
    logic [buffer_geom_pkg::line_addr_w-1:0] addr;
    for (int i = 0; i < len; i++)
    begin
      if (i % buffer_geom_pkg::lines_per_chunk == 0)
      begin
        check_chunk(fl_q, free_q[0], "chunk taken from free list");
        if (i == 0)
          head = free_q[0];
        else
          link_nxt[cur] = free_q[0];  // Link of the previous chunk.
        cur = free_q.pop_front();
        link_last[cur] = 1'b0;
      end
      addr = {cur, buffer_geom_pkg::offs_w'(i % buffer_geom_pkg::lines_per_chunk)};
      din = $urandom;
      mem_m[addr] = din;
      mem_v[addr] = 1'b1;
      wren = 1'b1;
      eop = i == len - 1;
      cycle();
    end
    link_last[cur] = 1'b1;
    wren = 1'b0;
    eop = 1'b0;
    settle();
  endtask

  // Mode 0 reads the whole chain, 1 releases from idle, 2 releases mid-read.
  task automatic serve_packet(input logic [buffer_geom_pkg::chunk_w-1:0] head, input int mode);
    logic [buffer_geom_pkg::chunk_w-1:0]     chain [$];
    logic [buffer_geom_pkg::line_addr_w-1:0] addr;
    int                                      total;
    int                                      n_read;
    chain.push_back(head);
    while (!link_last[chain[$]])
      chain.push_back(link_nxt[chain[$]]);
    total = chain.size() * buffer_geom_pkg::lines_per_chunk;
    if (mode == 0)
      n_read = total;
    else if (mode == 2)
      n_read = $urandom % total;
    else
      n_read = 0;
    chunk_num = head;
    if (mode == 1)
      rel_req = 1'b1;
    else
    begin
      load_req = 1'b1;
      cycle();
      load_req = 1'b0;
      check_flag(ack_s, 1'b0, "ack before prefetch");
      cycle();
      check_flag(ack_s, 1'b1, "load ack in prefetch");
      for (int p = 0; p < total; p++)
      begin
        if ($urandom % 4 == 0)
          cycle();  // Gap without rden while dout holds.
        addr = {chain[p / buffer_geom_pkg::lines_per_chunk],
                buffer_geom_pkg::offs_w'(p % buffer_geom_pkg::lines_per_chunk)};
        if (mem_v[addr])
          check_line(dout, mem_m[addr], "read line");
        if (p == n_read)
          break;
        rden = 1'b1;
        cycle();
        rden = 1'b0;
        check_flag(ack_s, 1'b0, "ack during read");
        if (p % buffer_geom_pkg::lines_per_chunk == buffer_geom_pkg::lines_per_chunk - 1)
          free_q.push_back(chain[p / buffer_geom_pkg::lines_per_chunk]);  // Freed on read-out.
      end
      rel_req = 1'b1;
    end
    cycle();
    rel_req = 1'b0;
    if (n_read == total)
      check_flag(ack_s, 1'b1, "ack on release after full read");
    else
    begin
      check_flag(ack_s, 1'b0, "ack at release start");
      while (!ack_s)
        cycle();
      for (int k = n_read / buffer_geom_pkg::lines_per_chunk; k < chain.size(); k++)
        free_q.push_back(chain[k]);
    end
    cycle();
    check_flag(ack_s, 1'b0, "ack longer than one cycle");
    settle();
  endtask

  task automatic random_traffic(input int count);
    logic [buffer_geom_pkg::chunk_w-1:0] head;
    repeat (count)
    begin
      write_packet(1 + $urandom % 10, head);
      serve_packet(head, $urandom % 3);
    end
  endtask

  initial
  begin
    logic [buffer_geom_pkg::chunk_w-1:0] head;
    int                                  len;
    void'($urandom(32'h33ce6cac));
    cycle_cnt = 0;
    ack_s     = 1'b0;
    reset_n   = 1'b0;
    wren      = 1'b0;
    din       = '0;
    eop       = 1'b0;
    chunk_num = '0;
    load_req  = 1'b0;
    rel_req   = 1'b0;
    rden      = 1'b0;
    repeat (5) @(posedge clk);
    @(negedge clk);
    reset_n = 1'b1;
    repeat (24) cycle();  // Three start cycles, then sixteen fill writes.
    for (int c = 0; c < buffer_geom_pkg::chunk_count; c++)
      free_q.push_back(buffer_geom_pkg::chunk_w'(c));
    check_chunk(fl_q, '0, "fl_q after fill");
    settle();
    random_traffic(40);
    while (free_q.size() > 0)
    begin
      if (free_q.size() == 1)
        len = 1;  // Later lines would land while fl_empty is high.
      else
        len = 1 + $urandom % buffer_geom_pkg::lines_per_chunk;
      write_packet(len, head);
      heads.push_back(head);
    end
    for (int i = 0; i < heads.size(); i++)
      serve_packet(heads[i], i % 2);
    random_traffic(40);
    $display("Everything OK");
    $finish;
  end

endmodule

`default_nettype wire

//--- chunk_buffer.f
logic/buffer_geom_pkg.sv
logic/buffer_ctrl_pkg.sv
logic/simple_dp_ram.sv
logic/free_chunk_fifo.sv
logic/chunk_write_ctrl.sv
logic/chunk_read_ctrl.sv
logic/chunk_buffer.sv
bench/chunk_buffer_tb.sv
